// ==== rtl/pipe.sv ====
// DEPTH of zero is a plain wire; RESET_VAL must be a legal constant of payload type T
`timescale 1ns/1ps
`default_nettype none

module pipe #(
	parameter type T         = logic,        // payload type
	parameter int  DEPTH     = 1,            // register stages
	parameter T    RESET_VAL = '0            // value after reset
) (
	input  wire   clk_i,                     // clock
	input  wire   rst_i,                     // async reset, active high
	input  wire T data_i,                    // payload in
	output T      data_o                     // payload out, DEPTH clocks later
);

	generate
		if (DEPTH == 0) begin : g_thru
			assign data_o = data_i;          // no delay
		end else begin : g_regs
			T stage_r [DEPTH];               // register chain

			always_ff @(posedge clk_i or posedge rst_i) begin
				if (rst_i) begin
					for (int i = 0; i < DEPTH; i++) begin
						stage_r[i] <= RESET_VAL;
					end
				end else begin
					stage_r[0] <= data_i;            // head of chain
					for (int i = 1; i < DEPTH; i++) begin
						stage_r[i] <= stage_r[i-1];  // shift along
					end
				end
			end

			assign data_o = stage_r[DEPTH-1];  // tail
		end
	endgenerate

endmodule

`default_nettype wire

// ==== rtl/pointer_ring.sv ====
// clr_i must never coincide with pop_i/push_i; errors are always reported, protection only guards levels
`timescale 1ns/1ps
`default_nettype none

module pointer_ring import stack_pkg::*; #(
	parameter int PNTR_W    = 5,             // stack pointer width
	parameter bit PROT_POP  = 1'b1,          // 1 = pop error leaves level alone
	parameter bit PROT_PUSH = 1'b1           // 1 = push error leaves level alone
) (
	input  wire                            clk_i,      // clock
	input  wire                            rst_i,      // async reset, active high
	input  wire                            clr_i,      // clear all stacks, stage 0
	input  wire  [STACKS-1:0]              pop_i,      // pop requests, stage 0
	input  wire  [STACKS-1:0]              push_i,     // push requests, stage 0
	output logic [STACKS-1:0][PNTR_W-1:0] pntr_o,     // stage 6 pointers
	output logic [STACKS-1:0]              wr_o,       // stage 6 write enables
	output logic [STACKS-1:0]              pop_er_o,   // stage 2 pop when empty
	output logic [STACKS-1:0]              push_er_o   // stage 3 push when full
);

	localparam int LEVEL_W = PNTR_W + 1;             // 0 .. 2^PNTR_W inclusive
	localparam logic [LEVEL_W-1:0] EMPTY_VAL = '0;
	localparam logic [LEVEL_W-1:0] FULL_VAL  = LEVEL_W'(1) << PNTR_W;
	localparam int STG_CLR = 1;                      // clear lands here
	localparam int STG_DEC = STG_POP_ER - 1;         // pop decode stage
	localparam int STG_INC = STG_PUSH_ER - 1;        // push decode stage
	localparam int WR_DLY  = STG_WR - STG_INC;       // inc to write enable

	// one level per stack, per ring stage
	logic [STACKS-1:0][LEVEL_W-1:0] level_r [THREADS];

	logic [STACKS-1:0] pop_1, push_1, push_2;        // staged requests
	logic [STACKS-1:0] empty_1, full_2;              // watermarks
	logic [STACKS-1:0] dec_1, inc_2;                 // effective changes
	logic [STACKS-1:0] pop_er_1, push_er_2;          // raw errors
	logic [2*STACKS-1:0] er_r;                       // registered errors

	// request staging, follows the thread around
	always_ff @(posedge clk_i or posedge rst_i) begin
		if (rst_i) begin
			pop_1  <= '0;
			push_1 <= '0;
			push_2 <= '0;
		end else begin
			pop_1  <= pop_i;
			push_1 <= push_i;
			push_2 <= push_1;                        // push waits for the pop
		end
	end

	// watermarks only where they are needed
	always_comb begin
		for (int s = 0; s < STACKS; s++) begin
			empty_1[s] = (level_r[STG_DEC][s] == EMPTY_VAL);   // after clear
			full_2[s]  = (level_r[STG_INC][s] == FULL_VAL);    // after pop
		end
	end

	// masking under protection
	assign dec_1 = PROT_POP  ? (pop_1  & ~empty_1) : pop_1;
	assign inc_2 = PROT_PUSH ? (push_2 & ~full_2)  : push_2;

	// errors; pop+push on full is fine since the pop made room
	assign pop_er_1  = pop_1  & empty_1;
	assign push_er_2 = push_2 & full_2;

	// level ring, rotate then modify at the tap stages
	always_ff @(posedge clk_i or posedge rst_i) begin
		if (rst_i) begin
			for (int t = 0; t < THREADS; t++) begin
				level_r[t] <= '0;                    // all stacks empty
			end
		end else begin
			level_r[0] <= level_r[THREADS-1];        // wrap around
			for (int t = 1; t < THREADS; t++) begin
				level_r[t] <= level_r[t-1];
			end
			for (int s = 0; s < STACKS; s++) begin
				level_r[STG_CLR][s] <= clr_i ? EMPTY_VAL : level_r[STG_CLR-1][s];
				if (dec_1[s]) begin
					level_r[STG_POP_ER][s] <= level_r[STG_DEC][s] - 1'b1;   // pop
				end
				if (inc_2[s]) begin
					level_r[STG_PUSH_ER][s] <= level_r[STG_INC][s] + 1'b1;  // push
				end
			end
		end
	end

	// effective pushes become write enables at STG_WR
	pipe #(
		.T         (logic [STACKS-1:0]),
		.DEPTH     (WR_DLY),
		.RESET_VAL ('0)
	) wr_pipe_i (
		.clk_i     (clk_i),
		.rst_i     (rst_i),
		.data_i    (inc_2),
		.data_o    (wr_o)
	);

	// one register on both error vectors
	pipe #(
		.T         (logic [2*STACKS-1:0]),
		.DEPTH     (1),
		.RESET_VAL ('0)
	) er_pipe_i (
		.clk_i     (clk_i),
		.rst_i     (rst_i),
		.data_i    ({pop_er_1, push_er_2}),
		.data_o    (er_r)
	);

	assign pop_er_o  = er_r[2*STACKS-1:STACKS];      // now at stage 2
	assign push_er_o = er_r[STACKS-1:0];             // now at stage 3

	// pointer is the level without its top bit; full maps to 0
	always_comb begin
		for (int s = 0; s < STACKS; s++) begin
			pntr_o[s] = level_r[STG_WR][s][PNTR_W-1:0];
		end
	end

endmodule

`default_nettype wire

// ==== rtl/stack_pkg.sv ====
// THREADS and STACKS are fixed at eight; the ring depth and every stage tap below rely on them
`default_nettype none

package stack_pkg;

	// thread ring geometry
	localparam int THREADS  = 8;                 // threads, also ring stages
	localparam int THREAD_W = $clog2(THREADS);   // thread index width
	localparam int STACKS   = 8;                 // LIFOs per thread

	// ring stage taps, counted from issue at stage 0
	// clear lands in stage 1, pop in stage 2, push in stage 3
	localparam int STG_POP_ER  = 2;              // pop errors out
	localparam int STG_PUSH_ER = 3;              // push errors out
	localparam int STG_WR      = 6;              // pointers & write enables out

	// top-of-stack path after the tap at STG_WR:
	//   STG_WR     ram address & write
	//   STG_WR+1   ram read register
	//   STG_WR+2   alignment register, equal to THREADS
	// so tos_o lines up with the issuing thread's next turn at stage 0

endpackage

`default_nettype wire

// ==== rtl/stack_ram.sv ====
// no reset since this maps to block RAM; a same-address write and read returns the new word
`timescale 1ns/1ps
`default_nettype none

module stack_ram import stack_pkg::*; #(
	parameter int PNTR_W = 5,                        // stack pointer width
	parameter int DATA_W = 32                        // stack word width
) (
	input  wire                         clk_i,       // clock
	input  wire                         wr_i,        // write enable, stage 6
	input  wire  [THREAD_W+PNTR_W-1:0] addr_i,      // {thread, pointer}
	input  wire  [DATA_W-1:0]           wdata_i,     // push word
	output logic [DATA_W-1:0]           rdata_o      // registered read
);

	localparam int ADDR_W = THREAD_W + PNTR_W;
	localparam int DEPTH  = 2 ** ADDR_W;             // every thread gets 2^PNTR_W words

	logic [DATA_W-1:0] mem_r [DEPTH];                // stack storage

	// single address for both sides
	// after a push the address is the new top, after a pop the one below
	always_ff @(posedge clk_i) begin
		if (wr_i) begin
			mem_r[addr_i] <= wdata_i;
			rdata_o       <= wdata_i;                // write first
		end else begin
			rdata_o       <= mem_r[addr_i];
		end
	end

endmodule

`default_nettype wire

// ==== rtl/stack_unit.sv ====
// inputs belong to the thread on thread_o; clr_i must not coincide with pop_i/push_i; tos_o valid when level nonzero
`timescale 1ns/1ps
`default_nettype none

module stack_unit import stack_pkg::*; #(
	parameter int PNTR_W    = 5,                     // stack pointer width
	parameter int DATA_W    = 32,                    // stack word width
	parameter bit PROT_POP  = 1'b1,                  // pop error protection
	parameter bit PROT_PUSH = 1'b1                   // push error protection
) (
	input  wire                            clk_i,       // clock
	input  wire                            rst_i,       // async reset, active high
	input  wire                            clr_i,       // clear all stacks of thread_o
	input  wire  [STACKS-1:0]              pop_i,       // pop per stack
	input  wire  [STACKS-1:0]              push_i,      // push per stack
	input  wire  [DATA_W-1:0]              push_data_i, // shared push word
	output logic [THREAD_W-1:0]            thread_o,    // thread at stage 0
	output logic [STACKS-1:0][DATA_W-1:0] tos_o,       // tops for thread_o
	output logic [STACKS-1:0]              pop_er_o,    // stage 2 pop errors
	output logic [STACKS-1:0]              push_er_o    // stage 3 push errors
);

	logic [THREAD_W-1:0]            thread_r;        // slot counter
	logic [THREAD_W-1:0]            thread_6;        // thread at write stage
	logic [DATA_W-1:0]              push_data_6;     // push word at write stage
	logic [STACKS-1:0][PNTR_W-1:0] pntr_6;          // ring pointers
	logic [STACKS-1:0]              wr_6;            // ring write enables
	logic [STACKS-1:0][DATA_W-1:0] rdata_7;         // ram read results
	logic [STACKS-1:0][DATA_W-1:0] tos_r;           // alignment register

	// thread slot, one per clock, wraps at THREADS
	always_ff @(posedge clk_i or posedge rst_i) begin
		if (rst_i) begin
			thread_r <= '0;
		end else if (thread_r == THREAD_W'(THREADS - 1)) begin
			thread_r <= '0;
		end else begin
			thread_r <= thread_r + 1'b1;
		end
	end

	assign thread_o = thread_r;

	// level tracking, errors and write enables
	pointer_ring #(
		.PNTR_W    (PNTR_W),
		.PROT_POP  (PROT_POP),
		.PROT_PUSH (PROT_PUSH)
	) ring_i (
		.clk_i     (clk_i),
		.rst_i     (rst_i),
		.clr_i     (clr_i),
		.pop_i     (pop_i),
		.push_i    (push_i),
		.pntr_o    (pntr_6),
		.wr_o      (wr_6),
		.pop_er_o  (pop_er_o),
		.push_er_o (push_er_o)
	);

	// push word rides along to the write stage
	pipe #(
		.T         (logic [DATA_W-1:0]),
		.DEPTH     (STG_WR),
		.RESET_VAL ('0)
	) data_pipe_i (
		.clk_i     (clk_i),
		.rst_i     (rst_i),
		.data_i    (push_data_i),
		.data_o    (push_data_6)
	);

	// so does the thread index, for the upper address bits
	pipe #(
		.T         (logic [THREAD_W-1:0]),
		.DEPTH     (STG_WR),
		.RESET_VAL ('0)
	) thread_pipe_i (
		.clk_i     (clk_i),
		.rst_i     (rst_i),
		.data_i    (thread_r),
		.data_o    (thread_6)
	);

	// one memory per stack, all threads share it by address
	generate
		for (genvar s = 0; s < STACKS; s++) begin : g_stack
			stack_ram #(
				.PNTR_W  (PNTR_W),
				.DATA_W  (DATA_W)
			) ram_i (
				.clk_i   (clk_i),
				.wr_i    (wr_6[s]),
				.addr_i  ({thread_6, pntr_6[s]}),   // thread selects the region
				.wdata_i (push_data_6),
				.rdata_o (rdata_7[s])
			);
		end
	endgenerate

	// one more register brings the tops back to stage 0
	always_ff @(posedge clk_i) begin
		tos_r <= rdata_7;
	end

	assign tos_o = tos_r;

endmodule

`default_nettype wire

// ==== sim/stack_unit_checker.sv ====
// bound into pointer_ring; sampled on clk_i and idle during reset, relies on the stage taps in stack_pkg
`timescale 1ns/1ps
`default_nettype none

module stack_unit_checker import stack_pkg::*; (
	input wire              clk_i,                     // ring clock
	input wire              rst_i,                     // ring reset
	input wire              clr_i,                     // clear at stage 0
	input wire [STACKS-1:0] pop_i,                     // pops at stage 0
	input wire [STACKS-1:0] push_i,                    // pushes at stage 0
	input wire [STACKS-1:0] wr_i,                      // ring write enables
	input wire [STACKS-1:0] pop_er_i,                  // ring pop errors
	input wire [STACKS-1:0] push_er_i                  // ring push errors
);

	int fail_cnt = 0;                                  // polled by the testbench

	// a write needs a push at issue
	wr_after_push: assert property (@(posedge clk_i) disable iff (rst_i)
		(wr_i & ~$past(push_i, STG_WR)) == '0)
	else begin
		fail_cnt++;
		$error("write enable without a push %0d cycles earlier", STG_WR);
	end

	pop_er_after_pop: assert property (@(posedge clk_i) disable iff (rst_i)
		(pop_er_i & ~$past(pop_i, STG_POP_ER)) == '0)
	else begin
		fail_cnt++;
		$error("pop error without a pop %0d cycles earlier", STG_POP_ER);
	end

	push_er_after_push: assert property (@(posedge clk_i) disable iff (rst_i)
		(push_er_i & ~$past(push_i, STG_PUSH_ER)) == '0)
	else begin
		fail_cnt++;
		$error("push error without a push %0d cycles earlier", STG_PUSH_ER);
	end

	// clear stands alone
	clr_alone: assert property (@(posedge clk_i) disable iff (rst_i)
		clr_i |-> (pop_i == '0 && push_i == '0))
	else begin
		fail_cnt++;
		$error("clear issued together with pop or push");
	end

endmodule

`default_nettype wire

// ==== sim/stack_unit_tb.sv ====
// runs PNTR_W=3 with both protections on (DUT defaults); clear is never driven together with pop/push
`timescale 1ns/1ps
`default_nettype none

module stack_unit_tb import stack_pkg::*; ();

	localparam int PNTR_W         = 3;                     // small stacks, full is common
	localparam int DATA_W         = 32;
	localparam int FULL_LVL       = 1 << PNTR_W;           // level of a full stack
	localparam int RESET_CYCLES   = 5;
	localparam int RANDOM_CYCLES  = 2048;                  // multiple of THREADS
	localparam int TOTAL_CYCLES   = RANDOM_CYCLES + 4 * THREADS;   // + clear test + drain
	localparam int TIMEOUT_CYCLES = TOTAL_CYCLES + 64;
	localparam int SEED           = 32'h0b7111ae;

	logic                            clk_i;
	logic                            rst_i;
	logic                            clr_i;
	logic [STACKS-1:0]               pop_i;
	logic [STACKS-1:0]               push_i;
	logic [DATA_W-1:0]               push_data_i;
	logic [THREAD_W-1:0]             thread_o;
	logic [STACKS-1:0][DATA_W-1:0]  tos_o;
	logic [STACKS-1:0]               pop_er_o;
	logic [STACKS-1:0]               push_er_o;

	integer seed;                                          // $random state
	int     cycle_cnt = 0;                                 // timeout counter

	// stimulus of the current cycle, kept for the model
	logic              cur_clr;
	logic [STACKS-1:0] cur_pop;
	logic [STACKS-1:0] cur_push;
	logic [DATA_W-1:0] cur_data;

	// reference model
	int                lvl_m  [THREADS][STACKS];            // fill level 0..FULL_LVL
	logic [DATA_W-1:0] word_m [THREADS][STACKS][FULL_LVL];  // indexed like the ram
	logic [STACKS-1:0] exp_pop_er  [TOTAL_CYCLES+4];        // by cycle of arrival
	logic [STACKS-1:0] exp_push_er [TOTAL_CYCLES+4];

	stack_unit #(
		.PNTR_W      (PNTR_W),
		.DATA_W      (DATA_W)
	) dut_i (
		.clk_i       (clk_i),
		.rst_i       (rst_i),
		.clr_i       (clr_i),
		.pop_i       (pop_i),
		.push_i      (push_i),
		.push_data_i (push_data_i),
		.thread_o    (thread_o),
		.tos_o       (tos_o),
		.pop_er_o    (pop_er_o),
		.push_er_o   (push_er_o)
	);

	bind pointer_ring stack_unit_checker ring_chk_i (
		.clk_i     (clk_i),
		.rst_i     (rst_i),
		.clr_i     (clr_i),
		.pop_i     (pop_i),
		.push_i    (push_i),
		.wr_i      (wr_o),
		.pop_er_i  (pop_er_o),
		.push_er_i (push_er_o)
	);

	initial begin
		clk_i = 1'b0;
		forever #2 clk_i = ~clk_i;                         // 4 ns period
	end

	task automatic abort_run();
		$display("Verification failed");
		$fatal(1, "run stopped at first error");
	endtask

	always @(posedge clk_i) begin
		cycle_cnt <= cycle_cnt + 1;
		if (cycle_cnt >= TIMEOUT_CYCLES) begin
			$display("timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
			abort_run();
		end
	end

	task automatic check_thread(input logic [THREAD_W-1:0] got, input logic [THREAD_W-1:0] exp);
		if (got !== exp) begin
			$display("MISMATCH at %0t: thread_o got %0d expected %0d", $time, got, exp);
			abort_run();
		end
	endtask

	task automatic check_error_vector(input string name, input logic [STACKS-1:0] got,
			input logic [STACKS-1:0] exp);
		if (got !== exp) begin
			$display("MISMATCH at %0t: %s got %b expected %b", $time, name, got, exp);
			abort_run();
		end
	endtask

	task automatic check_tos(input int thr, input int stk, input logic [DATA_W-1:0] got,
			input logic [DATA_W-1:0] exp);
		if (got !== exp) begin
			$display("MISMATCH at %0t: tos_o[%0d] of thread %0d got %h expected %h",
				$time, stk, thr, got, exp);
			abort_run();
		end
	endtask

	// random phase alternates push-heavy and pop-heavy blocks of 256 cycles
	task automatic pick_stimulus(input int cyc);
		int roll;
		int thr;
		bit push_heavy;
		thr        = cyc % THREADS;
		cur_clr    = 1'b0;
		cur_pop    = '0;
		cur_push   = '0;
		cur_data   = $random(seed);
		push_heavy = ((cyc >> 8) & 1) == 1;
		if (cyc < RANDOM_CYCLES) begin
			roll = $unsigned($random(seed)) % 64;
			if (roll < 2) begin
				cur_clr = 1'b1;                            // rare, nothing else
			end else if (roll >= 6) begin
				if (push_heavy) begin
					cur_push = $random(seed);
					cur_pop  = $random(seed) & $random(seed);
				end else begin
					cur_pop  = $random(seed);
					cur_push = $random(seed) & $random(seed);
				end
			end
		end else if (cyc < RANDOM_CYCLES + THREADS) begin
			cur_clr = (thr % 2 == 0);                      // clear even threads only
		end else if (cyc < RANDOM_CYCLES + 2 * THREADS) begin
			cur_pop = '1;                                  // pop everything, every thread
		end
	endtask

	// model of one issue at stage 0, protection on
	task automatic apply_ops(input int cyc);
		int thr;
		logic [STACKS-1:0] pe;
		logic [STACKS-1:0] he;
		thr = cyc % THREADS;
		pe  = '0;
		he  = '0;
		for (int s = 0; s < STACKS; s++) begin
			if (cur_clr) begin
				lvl_m[thr][s] = 0;
			end
			if (cur_pop[s]) begin
				if (lvl_m[thr][s] == 0) begin
					pe[s] = 1'b1;                          // empty, level kept
				end else begin
					lvl_m[thr][s]--;
				end
			end
			if (cur_push[s]) begin
				if (lvl_m[thr][s] == FULL_LVL) begin
					he[s] = 1'b1;                          // full after any pop
				end else begin
					lvl_m[thr][s]++;
					word_m[thr][s][lvl_m[thr][s] % FULL_LVL] = cur_data;
				end
			end
		end
		exp_pop_er[cyc + STG_POP_ER]   = pe;
		exp_push_er[cyc + STG_PUSH_ER] = he;
	endtask

	// outputs of one cycle, model still before this cycle's issue
	task automatic check_cycle(input int cyc);
		int thr;
		int lvl;
		thr = cyc % THREADS;
		check_thread(thread_o, THREAD_W'(thr));
		check_error_vector("pop_er_o", pop_er_o, exp_pop_er[cyc]);
		check_error_vector("push_er_o", push_er_o, exp_push_er[cyc]);
		for (int s = 0; s < STACKS; s++) begin
			lvl = lvl_m[thr][s];
			if (lvl != 0) begin
				check_tos(thr, s, tos_o[s], word_m[thr][s][lvl % FULL_LVL]);
			end
		end
		if (dut_i.ring_i.ring_chk_i.fail_cnt != 0) begin
			$display("a concurrent assertion in the ring checker failed");
			abort_run();
		end
	endtask

	initial begin : main_proc
		int cyc;
		seed        = SEED;
		rst_i       = 1'b1;
		clr_i       = 1'b0;
		pop_i       = '0;
		push_i      = '0;
		push_data_i = '0;
		for (int t = 0; t < THREADS; t++) begin
			for (int s = 0; s < STACKS; s++) begin
				lvl_m[t][s] = 0;
			end
		end
		for (int i = 0; i < TOTAL_CYCLES + 4; i++) begin
			exp_pop_er[i]  = '0;
			exp_push_er[i] = '0;
		end
		repeat (RESET_CYCLES) @(posedge clk_i);
		rst_i <= 1'b0;                                     // cycle 0 starts here, thread 0
		for (cyc = 0; cyc < TOTAL_CYCLES; cyc++) begin
			pick_stimulus(cyc);
			clr_i       <= cur_clr;
			pop_i       <= cur_pop;
			push_i      <= cur_push;
			push_data_i <= cur_data;
			@(negedge clk_i);                              // outputs settled
			check_cycle(cyc);
			apply_ops(cyc);
			@(posedge clk_i);
		end
		@(negedge clk_i);                                  // last edge's assertions settled
		if (dut_i.ring_i.ring_chk_i.fail_cnt == 0) begin
			$display("Verification passed");
			$finish;
		end else begin
			$display("ring checker reported %0d failures", dut_i.ring_i.ring_chk_i.fail_cnt);
			abort_run();
		end
	end

endmodule

`default_nettype wire

// ==== tb.f ====
rtl/stack_pkg.sv
rtl/pipe.sv
rtl/pointer_ring.sv
rtl/stack_ram.sv
rtl/stack_unit.sv
sim/stack_unit_checker.sv
sim/stack_unit_tb.sv
